// ==== src/csr_settings.svh ====
// RV32 only, fixed ID values below are read-only and not configurable at run time
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// --------------------
// widths
`define XLEN              32
`define CSR_ADDR_W        12
// low address bits that pick a bit in mcounteren / scounteren
`define CNT_IDX_W         5

// --------------------
// privilege codes
`define M_MODE            2'd3
`define S_MODE            2'd1
`define U_MODE            2'd0

// --------------------
// machine bank addresses
`define CSR_MSTATUS       12'h300
`define CSR_MISA          12'h301
`define CSR_MEDELEG       12'h302
`define CSR_MIDELEG       12'h303
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MCOUNTEREN    12'h306
`define CSR_MCOUNTINHIBIT 12'h320
`define CSR_MSCRATCH      12'h340
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MTVAL         12'h343
`define CSR_MIP           12'h344
`define CSR_MVENDORID     12'hF11
`define CSR_MARCHID       12'hF12
`define CSR_MIMPID        12'hF13
`define CSR_MHARTID       12'hF14

// supervisor bank addresses
`define CSR_SSTATUS       12'h100
`define CSR_SIE           12'h104
`define CSR_STVEC         12'h105
`define CSR_SCOUNTEREN    12'h106
`define CSR_SSCRATCH      12'h140
`define CSR_SEPC          12'h141
`define CSR_SCAUSE        12'h142
`define CSR_STVAL         12'h143
`define CSR_SIP           12'h144
`define CSR_SATP          12'h180

// counter bank addresses, machine view
`define CSR_MCYCLE        12'hB00
`define CSR_MINSTRET      12'hB02
`define CSR_MCYCLEH       12'hB80
`define CSR_MINSTRETH     12'hB82
// user view, read-only, gated by counter enables
`define CSR_CYCLE         12'hC00
`define CSR_TIME          12'hC01
`define CSR_INSTRET       12'hC02
`define CSR_CYCLEH        12'hC80
`define CSR_TIMEH         12'hC81
`define CSR_INSTRETH      12'hC82

// --------------------
// fixed read-only values
// misa: MXL=1 (32 bit), extensions I, M, S, U
`define MISA_VALUE        32'h4014_1100
`define VENDOR_ID         32'h0000_0000
`define ARCH_ID           32'h0000_0000
`define IMP_ID            32'h0000_0001
`define HART_ID           32'h0000_0000

`endif

// ==== src/csr_pkg.sv ====
// shared vector types for the CSR read path, widths come from csr_settings.svh
`include "csr_settings.svh"

package csr_pkg;

   // --------------------
   // register-wide value
   typedef logic [`XLEN-1:0]       xlen_t;

   // 64 bit counter or timer, split into lo/hi halves on read
   typedef logic [2*`XLEN-1:0]     dword_t;

   // CSR address as carried in the instruction
   typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

   // privilege mode code, see M_MODE / S_MODE / U_MODE
   typedef logic [1:0]             priv_mode_t;

   // --------------------
   // interrupt bits of one privilege level
   // [2] external, [1] timer, [0] software
   // same layout for enable and pending
   typedef logic [2:0]             irq_bits_t;

endpackage

// ==== src/csr_counter_access.sv ====
// U-mode needs both mcounteren and scounteren bits set, reserved mode codes deny
`include "csr_settings.svh"

module csr_counter_access
(
   input  csr_pkg::priv_mode_t    mode,
   input  logic [`CNT_IDX_W-1:0]  cnt_idx,
   input  csr_pkg::xlen_t         mcounteren,
   input  csr_pkg::xlen_t         scounteren,
   output logic                   cnt_av
);

   // --------------------
   // counter read permission
   // cnt_idx is the low address bits, 0 = CY, 1 = TM, 2 = IR
   always_comb
   begin
      case (mode)
         // machine mode sees every counter
         `M_MODE:
         begin
            cnt_av = 1'b1;
         end
         // supervisor gated by the machine enable only
         `S_MODE:
         begin
            cnt_av = mcounteren[cnt_idx];
         end
         // user needs both levels to pass it down
         `U_MODE:
         begin
            cnt_av = mcounteren[cnt_idx] & scounteren[cnt_idx];
         end
         // reserved code, deny
         default:
         begin
            cnt_av = 1'b0;
         end
      endcase
   end

endmodule

// ==== src/csr_machine_rd.sv ====
// machine-mode lookup only, misa and the ID registers are constants from the settings header
`include "csr_settings.svh"

module csr_machine_rd
(
   input  csr_pkg::csr_addr_t  csr_rd_addr,
   input  csr_pkg::xlen_t      mstatus,
   input  csr_pkg::xlen_t      medeleg,
   input  csr_pkg::xlen_t      mideleg,
   input  csr_pkg::xlen_t      mtvec,
   input  csr_pkg::xlen_t      mcounteren,
   input  csr_pkg::xlen_t      mcountinhibit,
   input  csr_pkg::xlen_t      mscratch,
   input  csr_pkg::xlen_t      mepc,
   input  csr_pkg::xlen_t      mcause,
   input  csr_pkg::xlen_t      mtval,
   input  csr_pkg::irq_bits_t  m_irq_en,
   input  csr_pkg::irq_bits_t  m_irq_pend,
   input  csr_pkg::irq_bits_t  s_irq_en,
   input  csr_pkg::irq_bits_t  s_irq_pend,
   output logic                machine_hit,
   output csr_pkg::xlen_t      machine_data
);

   import csr_pkg::*;

   xlen_t mie_word;
   xlen_t mip_word;

   // --------------------
   // mie / mip packing
   // bit 11/9 external, 7/5 timer, 3/1 software (machine/supervisor)
   // even bits and 31:12 read as zero
   assign mie_word = {20'b0,
                      m_irq_en[2], 1'b0, s_irq_en[2], 1'b0,
                      m_irq_en[1], 1'b0, s_irq_en[1], 1'b0,
                      m_irq_en[0], 1'b0, s_irq_en[0], 1'b0};

   assign mip_word = {20'b0,
                      m_irq_pend[2], 1'b0, s_irq_pend[2], 1'b0,
                      m_irq_pend[1], 1'b0, s_irq_pend[1], 1'b0,
                      m_irq_pend[0], 1'b0, s_irq_pend[0], 1'b0};

   // --------------------
   // address decode
   // hit by default, cleared for any address not in this bank
   always_comb
   begin
      machine_hit  = 1'b1;
      machine_data = '0;
      case (csr_rd_addr)
         // status and trap setup
         `CSR_MSTATUS:       machine_data = mstatus;
         `CSR_MISA:          machine_data = `MISA_VALUE;
         `CSR_MEDELEG:       machine_data = medeleg;
         `CSR_MIDELEG:       machine_data = mideleg;
         `CSR_MIE:           machine_data = mie_word;
         `CSR_MTVEC:         machine_data = mtvec;
         `CSR_MCOUNTEREN:    machine_data = mcounteren;
         // counter setup
         `CSR_MCOUNTINHIBIT: machine_data = mcountinhibit;
         // trap handling
         `CSR_MSCRATCH:      machine_data = mscratch;
         `CSR_MEPC:          machine_data = mepc;
         `CSR_MCAUSE:        machine_data = mcause;
         `CSR_MTVAL:         machine_data = mtval;
         `CSR_MIP:           machine_data = mip_word;
         // information registers, read-only constants
         `CSR_MVENDORID:     machine_data = `VENDOR_ID;
         `CSR_MARCHID:       machine_data = `ARCH_ID;
         `CSR_MIMPID:        machine_data = `IMP_ID;
         `CSR_MHARTID:       machine_data = `HART_ID;
         // not a machine register, data stays zero
         default:            machine_hit  = 1'b0;
      endcase
   end

endmodule

// ==== src/csr_super_rd.sv ====
// supervisor-mode lookup, no N extension so sedeleg/sideleg do not exist
`include "csr_settings.svh"

module csr_super_rd
(
   input  csr_pkg::csr_addr_t  csr_rd_addr,
   input  csr_pkg::xlen_t      sstatus,
   input  csr_pkg::xlen_t      stvec,
   input  csr_pkg::xlen_t      scounteren,
   input  csr_pkg::xlen_t      sscratch,
   input  csr_pkg::xlen_t      sepc,
   input  csr_pkg::xlen_t      scause,
   input  csr_pkg::xlen_t      stval,
   input  csr_pkg::xlen_t      satp,
   input  csr_pkg::irq_bits_t  s_irq_en,
   input  csr_pkg::irq_bits_t  s_irq_pend,
   output logic                super_hit,
   output csr_pkg::xlen_t      super_data
);

   import csr_pkg::*;

   xlen_t sie_word;
   xlen_t sip_word;

   // --------------------
   // sie / sip packing
   // external at 9, timer at 5, software at 1
   // machine bits are hidden from this view
   assign sie_word = {22'b0, s_irq_en[2], 3'b0, s_irq_en[1], 3'b0, s_irq_en[0], 1'b0};
   assign sip_word = {22'b0, s_irq_pend[2], 3'b0, s_irq_pend[1], 3'b0, s_irq_pend[0], 1'b0};

   // --------------------
   // address decode
   always_comb
   begin
      super_hit  = 1'b1;
      super_data = '0;
      case (csr_rd_addr)
         // status and trap setup
         `CSR_SSTATUS:    super_data = sstatus;
         `CSR_SIE:        super_data = sie_word;
         `CSR_STVEC:      super_data = stvec;
         `CSR_SCOUNTEREN: super_data = scounteren;
         // trap handling
         `CSR_SSCRATCH:   super_data = sscratch;
         `CSR_SEPC:       super_data = sepc;
         `CSR_SCAUSE:     super_data = scause;
         // stval reads its own register here
         `CSR_STVAL:      super_data = stval;
         `CSR_SIP:        super_data = sip_word;
         // address translation
         `CSR_SATP:       super_data = satp;
         default:         super_hit  = 1'b0;
      endcase
   end

endmodule

// ==== src/csr_counter_rd.sv ====
// only cycle, time and instret, no hpm counters; user view needs cnt_av from the access check
`include "csr_settings.svh"

module csr_counter_rd
(
   input  csr_pkg::csr_addr_t  csr_rd_addr,
   input  csr_pkg::dword_t     mcycle,
   input  csr_pkg::dword_t     minstret,
   input  csr_pkg::dword_t     mtime,
   input  logic                cnt_av,
   output logic                counter_hit,
   output csr_pkg::xlen_t      counter_data
);

   import csr_pkg::*;

   logic  mach_sel;
   logic  user_sel;
   xlen_t sel_data;

   // --------------------
   // half select
   // machine view always readable, user view only when permitted
   always_comb
   begin
      mach_sel = 1'b0;
      user_sel = 1'b0;
      sel_data = '0;
      case (csr_rd_addr)
         `CSR_MCYCLE:    begin mach_sel = 1'b1; sel_data = mcycle[`XLEN-1:0];          end
         `CSR_MINSTRET:  begin mach_sel = 1'b1; sel_data = minstret[`XLEN-1:0];        end
         `CSR_MCYCLEH:   begin mach_sel = 1'b1; sel_data = mcycle[2*`XLEN-1:`XLEN];    end
         `CSR_MINSTRETH: begin mach_sel = 1'b1; sel_data = minstret[2*`XLEN-1:`XLEN];  end
         // user view, time comes from the platform timer
         `CSR_CYCLE:     begin user_sel = 1'b1; sel_data = mcycle[`XLEN-1:0];          end
         `CSR_TIME:      begin user_sel = 1'b1; sel_data = mtime[`XLEN-1:0];           end
         `CSR_INSTRET:   begin user_sel = 1'b1; sel_data = minstret[`XLEN-1:0];        end
         `CSR_CYCLEH:    begin user_sel = 1'b1; sel_data = mcycle[2*`XLEN-1:`XLEN];    end
         `CSR_TIMEH:     begin user_sel = 1'b1; sel_data = mtime[2*`XLEN-1:`XLEN];     end
         `CSR_INSTRETH:  begin user_sel = 1'b1; sel_data = minstret[2*`XLEN-1:`XLEN];  end
         default:        sel_data = '0;
      endcase
   end

   // --------------------
   // denied user read looks like a missing register
   assign counter_hit  = mach_sel | (user_sel & cnt_av);

   // zero data without a hit so the merge can OR the banks
   assign counter_data = counter_hit ? sel_data : '0;

endmodule

// ==== src/csr_rd_merge.sv ====
// banks must drive zero data when they miss, and address ranges must not overlap
`include "csr_settings.svh"

module csr_rd_merge
(
   input  logic            clk,
   input  logic            reset,
   input  logic            machine_hit,
   input  logic            super_hit,
   input  logic            counter_hit,
   input  csr_pkg::xlen_t  machine_data,
   input  csr_pkg::xlen_t  super_data,
   input  csr_pkg::xlen_t  counter_data,
   output logic            csr_rd_avail,
   output csr_pkg::xlen_t  csr_rd_data
);

   import csr_pkg::*;

   logic  any_hit;
   xlen_t any_data;

   // --------------------
   // combine banks
   // at most one bank hits, the others contribute zeros
   assign any_hit  = machine_hit | super_hit | counter_hit;
   assign any_data = machine_data | super_data | counter_data;

   // --------------------
   // response register, one read per cycle, no stall
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         csr_rd_avail <= 1'b0;
         csr_rd_data  <= '0;
      end
      else
      begin
         csr_rd_avail <= any_hit;
         csr_rd_data  <= any_data;
      end
   end

endmodule

// ==== src/csr_av_rdata.sv ====
// read result appears one cycle after the address; no N ext, PMP, hpm counters or debug CSRs
`include "csr_settings.svh"

module csr_av_rdata
(
   input  logic                clk,
   input  logic                reset,

   // read request, sampled every cycle
   input  csr_pkg::csr_addr_t  csr_rd_addr,
   input  csr_pkg::priv_mode_t mode,

   // machine registers
   input  csr_pkg::xlen_t      mstatus,
   input  csr_pkg::xlen_t      medeleg,
   input  csr_pkg::xlen_t      mideleg,
   input  csr_pkg::xlen_t      mtvec,
   input  csr_pkg::xlen_t      mcounteren,
   input  csr_pkg::xlen_t      mcountinhibit,
   input  csr_pkg::xlen_t      mscratch,
   input  csr_pkg::xlen_t      mepc,
   input  csr_pkg::xlen_t      mcause,
   input  csr_pkg::xlen_t      mtval,
   input  csr_pkg::irq_bits_t  m_irq_en,
   input  csr_pkg::irq_bits_t  m_irq_pend,

   // supervisor registers
   input  csr_pkg::xlen_t      sstatus,
   input  csr_pkg::xlen_t      stvec,
   input  csr_pkg::xlen_t      scounteren,
   input  csr_pkg::xlen_t      sscratch,
   input  csr_pkg::xlen_t      sepc,
   input  csr_pkg::xlen_t      scause,
   input  csr_pkg::xlen_t      stval,
   input  csr_pkg::xlen_t      satp,
   input  csr_pkg::irq_bits_t  s_irq_en,
   input  csr_pkg::irq_bits_t  s_irq_pend,

   // counters and platform timer
   input  csr_pkg::dword_t     mcycle,
   input  csr_pkg::dword_t     minstret,
   input  csr_pkg::dword_t     mtime,

   // registered response
   output csr_pkg::xlen_t      csr_rd_data,
   output logic                csr_rd_avail
);

   import csr_pkg::*;

   logic  cnt_av;
   logic  machine_hit;
   logic  super_hit;
   logic  counter_hit;
   xlen_t machine_data;
   xlen_t super_data;
   xlen_t counter_data;

   // --------------------
   // counter permission, low address bits pick the enable bit
   csr_counter_access u_counter_access
   (
      .mode         (mode),
      .cnt_idx      (csr_rd_addr[`CNT_IDX_W-1:0]),
      .mcounteren   (mcounteren),
      .scounteren   (scounteren),
      .cnt_av       (cnt_av)
   );

   // --------------------
   // register banks
   csr_machine_rd u_machine_rd
   (
      .csr_rd_addr   (csr_rd_addr),
      .mstatus       (mstatus),
      .medeleg       (medeleg),
      .mideleg       (mideleg),
      .mtvec         (mtvec),
      .mcounteren    (mcounteren),
      .mcountinhibit (mcountinhibit),
      .mscratch      (mscratch),
      .mepc          (mepc),
      .mcause        (mcause),
      .mtval         (mtval),
      .m_irq_en      (m_irq_en),
      .m_irq_pend    (m_irq_pend),
      .s_irq_en      (s_irq_en),
      .s_irq_pend    (s_irq_pend),
      .machine_hit   (machine_hit),
      .machine_data  (machine_data)
   );

   csr_super_rd u_super_rd
   (
      .csr_rd_addr  (csr_rd_addr),
      .sstatus      (sstatus),
      .stvec        (stvec),
      .scounteren   (scounteren),
      .sscratch     (sscratch),
      .sepc         (sepc),
      .scause       (scause),
      .stval        (stval),
      .satp         (satp),
      .s_irq_en     (s_irq_en),
      .s_irq_pend   (s_irq_pend),
      .super_hit    (super_hit),
      .super_data   (super_data)
   );

   csr_counter_rd u_counter_rd
   (
      .csr_rd_addr  (csr_rd_addr),
      .mcycle       (mcycle),
      .minstret     (minstret),
      .mtime        (mtime),
      .cnt_av       (cnt_av),
      .counter_hit  (counter_hit),
      .counter_data (counter_data)
   );

   // --------------------
   // merge and register
   csr_rd_merge u_rd_merge
   (
      .clk          (clk),
      .reset        (reset),
      .machine_hit  (machine_hit),
      .super_hit    (super_hit),
      .counter_hit  (counter_hit),
      .machine_data (machine_data),
      .super_data   (super_data),
      .counter_data (counter_data),
      .csr_rd_avail (csr_rd_avail),
      .csr_rd_data  (csr_rd_data)
   );

endmodule

// ==== tests/tb_csr_av_rdata.sv ====
// address and mode are plain levels with no handshake; expects one-cycle latency, zero after reset
`include "csr_settings.svh"

module tb_csr_av_rdata;

   timeunit 1ns;
   timeprecision 1ns;

   import csr_pkg::*;

   localparam int kept_n        = 37;
   // first counter address in the list below
   localparam int counter_first = 27;
   localparam int reset_limit   = 20;
   localparam int drain_limit   = 10;

   // every address this design implements
   localparam csr_addr_t kept_addrs [kept_n] = '{
      `CSR_MSTATUS, `CSR_MISA, `CSR_MEDELEG, `CSR_MIDELEG, `CSR_MIE, `CSR_MTVEC,
      `CSR_MCOUNTEREN, `CSR_MCOUNTINHIBIT, `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE,
      `CSR_MTVAL, `CSR_MIP, `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID,
      `CSR_SSTATUS, `CSR_SIE, `CSR_STVEC, `CSR_SCOUNTEREN, `CSR_SSCRATCH, `CSR_SEPC,
      `CSR_SCAUSE, `CSR_STVAL, `CSR_SIP, `CSR_SATP,
      `CSR_MCYCLE, `CSR_MINSTRET, `CSR_MCYCLEH, `CSR_MINSTRETH,
      `CSR_CYCLE, `CSR_TIME, `CSR_INSTRET, `CSR_CYCLEH, `CSR_TIMEH, `CSR_INSTRETH
   };

   // dropped features: user trap, sedeleg/sideleg, PMP, debug, hpm
   localparam csr_addr_t dropped_addrs [14] = '{
      12'h000, 12'h004, 12'h005, 12'h040, 12'h044, 12'h102, 12'h103,
      12'h3A0, 12'h3B0, 12'h7A0, 12'h7B0, 12'h7B1, 12'hB03, 12'hC03
   };

   logic clk = 1'b0;
   logic reset = 1'b1;
   // misa is mapped, so the outputs read zero during reset only because of the reset
   csr_addr_t  csr_rd_addr = `CSR_MISA;
   priv_mode_t mode = `M_MODE;
   xlen_t mstatus = '0, medeleg = '0, mideleg = '0, mtvec = '0, mcounteren = '0;
   xlen_t mcountinhibit = '0, mscratch = '0, mepc = '0, mcause = '0, mtval = '0;
   xlen_t sstatus = '0, stvec = '0, scounteren = '0, sscratch = '0;
   xlen_t sepc = '0, scause = '0, stval = '0, satp = '0;
   irq_bits_t m_irq_en = '0, m_irq_pend = '0, s_irq_en = '0, s_irq_pend = '0;
   dword_t mcycle = '0, minstret = '0, mtime = '0;
   xlen_t csr_rd_data;
   logic  csr_rd_avail;

   integer seed = 32'he0cd;
   logic [15:0] read_tag = '0;
   // model state, one cycle behind the inputs like the DUT
   logic        exp_avail_q = 1'b0;
   xlen_t       exp_data_q = '0;
   logic [15:0] exp_tag_q = '0;
   logic        chk_on = 1'b0;

   // port names match the testbench signals
   csr_av_rdata u_csr_av_rdata (.*);

   always #50 clk = ~clk;

   // --------------------
   // reference model
   function automatic logic [31:0] next_rand();
      return $unsigned($random(seed));
   endfunction

   // machine bits at 11/7/3, supervisor bits at 9/5/1
   function automatic xlen_t pack_irq(input irq_bits_t mach, input irq_bits_t sup);
      xlen_t w;
      w     = '0;
      w[11] = mach[2];
      w[7]  = mach[1];
      w[3]  = mach[0];
      w[9]  = sup[2];
      w[5]  = sup[1];
      w[1]  = sup[0];
      return w;
   endfunction

   // returns {avail, data}
   function automatic logic [32:0] model_read(input csr_addr_t a, input priv_mode_t m);
      logic  av;
      logic  perm;
      xlen_t d;
      av = 1'b1;
      d  = '0;
      case (m)
         `M_MODE: perm = 1'b1;
         `S_MODE: perm = mcounteren[a[`CNT_IDX_W-1:0]];
         `U_MODE: perm = mcounteren[a[`CNT_IDX_W-1:0]] & scounteren[a[`CNT_IDX_W-1:0]];
         default: perm = 1'b0;
      endcase
      case (a)
         `CSR_MSTATUS: d = mstatus;
         `CSR_MISA: d = `MISA_VALUE;
         `CSR_MEDELEG: d = medeleg;
         `CSR_MIDELEG: d = mideleg;
         `CSR_MIE: d = pack_irq(m_irq_en, s_irq_en);
         `CSR_MTVEC: d = mtvec;
         `CSR_MCOUNTEREN: d = mcounteren;
         `CSR_MCOUNTINHIBIT: d = mcountinhibit;
         `CSR_MSCRATCH: d = mscratch;
         `CSR_MEPC: d = mepc;
         `CSR_MCAUSE: d = mcause;
         `CSR_MTVAL: d = mtval;
         `CSR_MIP: d = pack_irq(m_irq_pend, s_irq_pend);
         `CSR_MVENDORID: d = `VENDOR_ID;
         `CSR_MARCHID: d = `ARCH_ID;
         `CSR_MIMPID: d = `IMP_ID;
         `CSR_MHARTID: d = `HART_ID;
         `CSR_SSTATUS: d = sstatus;
         `CSR_SIE: d = pack_irq(3'b000, s_irq_en);
         `CSR_STVEC: d = stvec;
         `CSR_SCOUNTEREN: d = scounteren;
         `CSR_SSCRATCH: d = sscratch;
         `CSR_SEPC: d = sepc;
         `CSR_SCAUSE: d = scause;
         `CSR_STVAL: d = stval;
         `CSR_SIP: d = pack_irq(3'b000, s_irq_pend);
         `CSR_SATP: d = satp;
         `CSR_MCYCLE: d = mcycle[31:0];
         `CSR_MINSTRET: d = minstret[31:0];
         `CSR_MCYCLEH: d = mcycle[63:32];
         `CSR_MINSTRETH: d = minstret[63:32];
         // user view, denied reads look like missing registers
         `CSR_CYCLE: {av, d} = perm ? {1'b1, mcycle[31:0]} : 33'd0;
         `CSR_TIME: {av, d} = perm ? {1'b1, mtime[31:0]} : 33'd0;
         `CSR_INSTRET: {av, d} = perm ? {1'b1, minstret[31:0]} : 33'd0;
         `CSR_CYCLEH: {av, d} = perm ? {1'b1, mcycle[63:32]} : 33'd0;
         `CSR_TIMEH: {av, d} = perm ? {1'b1, mtime[63:32]} : 33'd0;
         `CSR_INSTRETH: {av, d} = perm ? {1'b1, minstret[63:32]} : 33'd0;
         default: av = 1'b0;
      endcase
      return {av, d};
   endfunction

   function automatic logic is_kept(input csr_addr_t a);
      foreach (kept_addrs[i])
         if (kept_addrs[i] == a)
            return 1'b1;
      return 1'b0;
   endfunction

   // expectation for the inputs seen at this edge
   always @(posedge clk)
   begin
      if (reset)
      begin
         {exp_avail_q, exp_data_q} <= 33'd0;
         exp_tag_q <= '0;
      end
      else
      begin
         {exp_avail_q, exp_data_q} <= model_read(csr_rd_addr, mode);
         exp_tag_q <= read_tag;
      end
   end

   // no output is defined before the first edge
   always @(posedge clk)
      chk_on <= 1'b1;

   // --------------------
   // checks
   task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp);
      $display("STATUS: FAIL");
      $display("Error: time %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $fatal(1, "read response mismatch");
   endtask

   task automatic timeout_fail(input string what);
      $display("STATUS: FAIL");
      $display("timed out while waiting for %s", what);
      $fatal(1, "timeout");
   endtask

   // outputs and model settle at the rising edge, compared half a cycle later
   avail_check: assert property (@(negedge clk) disable iff (!chk_on)
                                 csr_rd_avail == exp_avail_q)
      else report_mismatch("csr_rd_avail", 32'(csr_rd_avail), 32'(exp_avail_q));

   data_check: assert property (@(negedge clk) disable iff (!chk_on)
                                csr_rd_data == exp_data_q)
      else report_mismatch("csr_rd_data", csr_rd_data, exp_data_q);

   // --------------------
   // stimulus
   task automatic randomize_regs();
      mstatus       <= next_rand();
      medeleg       <= next_rand();
      mideleg       <= next_rand();
      mtvec         <= next_rand();
      mcounteren    <= next_rand();
      mcountinhibit <= next_rand();
      mscratch      <= next_rand();
      mepc          <= next_rand();
      mcause        <= next_rand();
      mtval         <= next_rand();
      sstatus       <= next_rand();
      stvec         <= next_rand();
      scounteren    <= next_rand();
      sscratch      <= next_rand();
      sepc          <= next_rand();
      scause        <= next_rand();
      stval         <= next_rand();
      satp          <= next_rand();
      m_irq_en      <= 3'(next_rand());
      m_irq_pend    <= 3'(next_rand());
      s_irq_en      <= 3'(next_rand());
      s_irq_pend    <= 3'(next_rand());
      mcycle        <= {next_rand(), next_rand()};
      minstret      <= {next_rand(), next_rand()};
      mtime         <= {next_rand(), next_rand()};
   endtask

   task automatic drive_read(input csr_addr_t a, input priv_mode_t m, input logic rerand);
      @(posedge clk);
      csr_rd_addr <= a;
      mode        <= m;
      read_tag    <= read_tag + 16'd1;
      if (rerand)
         randomize_regs();
   endtask

   // until the model holds the last issued read, then let its check run
   task automatic wait_drain(input string what);
      int cycles;
      cycles = 0;
      while (exp_tag_q != read_tag)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > drain_limit)
            timeout_fail(what);
      end
      @(posedge clk);
   endtask

   initial
   begin
      repeat (8) @(posedge clk);
      reset <= 1'b0;
   end

   initial
   begin
      int cycles;
      csr_addr_t a;
      cycles = 0;
      while (reset)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > reset_limit)
            timeout_fail("reset release");
      end

      // machine and supervisor map plus counters, all in M-mode
      for (int rep = 0; rep < 4; rep++)
         foreach (kept_addrs[i])
            drive_read(kept_addrs[i], `M_MODE, i % 5 == 0);
      wait_drain("machine-mode reads");

      // counter enables under S-mode and U-mode
      for (int rep = 0; rep < 24; rep++)
      begin
         for (int i = counter_first; i < kept_n; i++)
            drive_read(kept_addrs[i], `S_MODE, i == counter_first);
         for (int i = counter_first; i < kept_n; i++)
            drive_read(kept_addrs[i], `U_MODE, 1'b0);
      end
      wait_drain("counter access reads");

      // addresses outside the map
      foreach (dropped_addrs[i])
         drive_read(dropped_addrs[i], `M_MODE, 1'b1);
      for (int n = 0; n < 200; n++)
      begin
         a = csr_addr_t'(next_rand());
         if (!is_kept(a))
            drive_read(a, priv_mode_t'(next_rand()), 1'b0);
      end
      wait_drain("unmapped reads");

      // back-to-back mix, mostly mapped addresses
      for (int n = 0; n < 600; n++)
      begin
         if (next_rand() % 4 != 0)
            a = kept_addrs[int'(next_rand() % 32'(kept_n))];
         else
            a = csr_addr_t'(next_rand());
         drive_read(a, priv_mode_t'(next_rand()), 1'b1);
      end
      wait_drain("back-to-back reads");

      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== csr_av_rdata.f ====
+incdir+src
src/csr_pkg.sv
src/csr_counter_access.sv
src/csr_machine_rd.sv
src/csr_super_rd.sv
src/csr_counter_rd.sv
src/csr_rd_merge.sv
src/csr_av_rdata.sv
tests/tb_csr_av_rdata.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    := tb_csr_av_rdata
RTL_TOP   := csr_av_rdata
FILELIST  := csr_av_rdata.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
